// File: source/cache_geom_pkg.sv
package cache_geom_pkg;

////////////////////////////////////////////////////////////////////////
// word and line geometry
////////////////////////////////////////////////////////////////////////

localparam int word_bits      = 32;
localparam int words_per_line = 4;
localparam int offset_bits    = 4;                  // byte offset inside a line

typedef logic [word_bits-1:0]                word_t;
typedef logic [word_bits*words_per_line-1:0] line_t;
typedef logic [31:0]                         addr_t;  // byte address

// selects one word of a line
typedef logic [$clog2(words_per_line)-1:0]   word_sel_t;

endpackage

// File: source/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

// controller sequence, a miss runs evict (dirty only) then refill then lookup again
typedef enum logic [2:0] {
        idle,
        lookup,
        evict,
        evict_wait,
        refill,
        refill_wait
} ctrl_state_t;

typedef enum logic {
        op_read,
        op_write
} cache_op_t;

endpackage

// File: source/cache_ifs.sv
`timescale 1ns/1ns

////////////////////////////////////////////////////////////////////////
// tag lookup bus between controller and tag store
////////////////////////////////////////////////////////////////////////

interface way_if
        import cache_geom_pkg::*;
        #(parameter int sets = 2);

localparam int idx_w = $clog2(sets);
localparam int tag_w = $bits(addr_t) - offset_bits - idx_w;

logic [idx_w-1:0] index;
logic [tag_w-1:0] tag;
logic             touch;                            // make way the recent one
logic             fill;                             // install tag, valid and clean
logic             mark_dirty;
logic             way;
logic             hit;
logic             hit_way;
logic             victim_way;
logic             victim_dirty;
logic [tag_w-1:0] victim_tag;

modport ctrl (output index, tag, touch, fill, mark_dirty, way,
              input  hit, hit_way, victim_way, victim_dirty, victim_tag);

modport store (input  index, tag, touch, fill, mark_dirty, way,
               output hit, hit_way, victim_way, victim_dirty, victim_tag);

endinterface

////////////////////////////////////////////////////////////////////////
// line data bus between controller and line store
////////////////////////////////////////////////////////////////////////

interface line_if
        import cache_geom_pkg::*;
        #(parameter int sets = 2);

localparam int idx_w = $clog2(sets);

logic [idx_w-1:0] index;
logic             way;
word_sel_t        word_sel;
logic             byte_sel;
logic [1:0]       byte_off;                         // byte within the word
word_t            wdata;
logic             write_word;
logic             fill_line;
line_t            fill_data;
word_t            rdata;
line_t            victim_line;

modport ctrl (output index, way, word_sel, byte_sel, byte_off, wdata,
                     write_word, fill_line, fill_data,
              input  rdata, victim_line);

modport store (input  index, way, word_sel, byte_sel, byte_off, wdata,
                      write_word, fill_line, fill_data,
               output rdata, victim_line);

endinterface

// File: source/tag_store.sv
`timescale 1ns/1ns

module tag_store
        import cache_geom_pkg::*;
        #(parameter int sets = 2)
        (
        input  logic clk,
        input  logic reset,
        way_if.store way
        );

localparam int idx_w = $clog2(sets);
localparam int tag_w = $bits(addr_t) - offset_bits - idx_w;

logic [tag_w-1:0] tag_mem [0:1][0:sets-1];
logic [1:0]       valid_q [0:sets-1];               // one bit per way
logic [1:0]       dirty_q [0:sets-1];
logic [sets-1:0]  lru_q;                            // way to replace next
logic [1:0]       match;

////////////////////////////////////////////////////////////////////////
// parallel compare and victim choice
////////////////////////////////////////////////////////////////////////

always_comb
begin
        for (int w = 0; w < 2; w++)
        begin
                match[w] = valid_q[way.index][w] && (tag_mem[w][way.index] == way.tag);
        end
end

assign way.hit          = |match;
assign way.hit_way      = match[1];                 // both ways never hold the same tag
assign way.victim_way   = lru_q[way.index];
assign way.victim_dirty = dirty_q[way.index][lru_q[way.index]];
assign way.victim_tag   = tag_mem[lru_q[way.index]][way.index];

////////////////////////////////////////////////////////////////////////
// state bits
////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk or posedge reset)
begin
        if (reset)
        begin
                for (int s = 0; s < sets; s++)
                begin
                        valid_q[s] <= '0;
                        dirty_q[s] <= '0;
                end
                lru_q <= '0;
        end
        else
        begin
                if (way.fill)
                begin
                        valid_q[way.index][way.way] <= 1'b1;
                        dirty_q[way.index][way.way] <= 1'b0;   // refilled line is clean
                end
                if (way.mark_dirty)
                        dirty_q[way.index][way.way] <= 1'b1;
                if (way.touch || way.fill)
                        lru_q[way.index] <= ~way.way;   // the other way becomes victim
        end
end

always_ff @(posedge clk)
begin
        if (way.fill)
                tag_mem[way.way][way.index] <= way.tag;
end

endmodule

// File: source/line_store.sv
`timescale 1ns/1ns

module line_store
        import cache_geom_pkg::*;
        #(parameter int sets = 2)
        (
        input  logic  clk,
        input  logic  reset,
        line_if.store line
        );

line_t data_mem [0:1][0:sets-1];
line_t cur_line;
word_t cur_word;

////////////////////////////////////////////////////////////////////////
// read side
////////////////////////////////////////////////////////////////////////

assign cur_line = data_mem[line.way][line.index];
assign cur_word = cur_line[line.word_sel*word_bits +: word_bits];

always_comb
begin
        if (line.byte_sel)
                line.rdata = {{(word_bits-8){1'b0}}, cur_word[line.byte_off*8 +: 8]};
        else
                line.rdata = cur_word;
end

assign line.victim_line = cur_line;                 // whole line for write-back

////////////////////////////////////////////////////////////////////////
// write side
////////////////////////////////////////////////////////////////////////

// no updates land while reset is held
always_ff @(posedge clk)
begin
        if (!reset)
        begin
                if (line.fill_line)
                        data_mem[line.way][line.index] <= line.fill_data;
                else if (line.write_word)
                        data_mem[line.way][line.index][line.word_sel*word_bits +: word_bits]
                                <= line.wdata;
        end
end

endmodule

// File: source/cache_control.sv
`timescale 1ns/1ns

module cache_control
        import cache_geom_pkg::*;
        import cache_ctrl_pkg::*;
        (
        input  logic   clk,
        input  logic   reset,
        input  logic   read_cpu,
        input  logic   write_cpu,
        input  logic   byte_sel,
        input  addr_t  addr_cpu,
        input  word_t  wdata_cpu,
        input  line_t  mem_rdata,
        input  logic   mem_done,
        output logic   resp_valid,
        output logic   busy,
        output logic   mem_read,
        output logic   mem_write,
        output addr_t  mem_addr,
        output line_t  mem_wdata,
        way_if.ctrl    way,
        line_if.ctrl   line
        );

localparam int idx_w  = $bits(way.index);
localparam int tag_w  = $bits(way.tag);
localparam int addr_w = $bits(addr_t);

ctrl_state_t state;
cache_op_t   req_op;
addr_t       req_addr;
word_t       req_wdata;
logic        req_byte;
logic        req_pending;                           // request taken, lookup starts next edge
logic        miss_way;                              // way chosen for replacement
logic        accept;
logic        hit_now;
logic        sel_way;

assign accept  = (state == idle) && !req_pending && (read_cpu || write_cpu);
assign hit_now = (state == lookup) && way.hit;

// during a miss the replacement way is held, otherwise follow the hit
assign sel_way = (state inside {evict, evict_wait, refill, refill_wait}) ? miss_way
                                                                          : way.hit_way;

////////////////////////////////////////////////////////////////////////
// store requests
////////////////////////////////////////////////////////////////////////

assign way.index      = req_addr[offset_bits +: idx_w];
assign way.tag        = req_addr[addr_w-1 -: tag_w];
assign way.way        = sel_way;
assign way.touch      = hit_now;
assign way.mark_dirty = hit_now && (req_op == op_write);
assign way.fill       = (state == refill_wait) && mem_done;

assign line.index      = req_addr[offset_bits +: idx_w];
assign line.way        = sel_way;
assign line.word_sel   = req_addr[2 +: $bits(word_sel_t)];
assign line.byte_sel   = req_byte;
assign line.byte_off   = req_addr[1:0];
assign line.wdata      = req_wdata;
assign line.write_word = hit_now && (req_op == op_write);   // merge on write hit
assign line.fill_line  = (state == refill_wait) && mem_done;
assign line.fill_data  = mem_rdata;

////////////////////////////////////////////////////////////////////////
// controller FSM
////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk or posedge reset)
begin
        if (reset)
        begin
                state       <= idle;
                req_op      <= op_read;
                req_pending <= 1'b0;
                miss_way    <= 1'b0;
                busy        <= 1'b0;
                resp_valid  <= 1'b0;
                mem_read    <= 1'b0;
                mem_write   <= 1'b0;
        end
        else
        begin
                resp_valid <= 1'b0;                 // all strobes last one cycle
                mem_read   <= 1'b0;
                mem_write  <= 1'b0;
                case (state)
                        idle:
                        begin
                                if (req_pending)
                                begin
                                        req_pending <= 1'b0;
                                        busy        <= 1'b1;
                                        state       <= lookup;
                                end
                                else if (accept)
                                begin
                                        req_pending <= 1'b1;
                                        req_op      <= write_cpu ? op_write : op_read;
                                end
                        end
                        lookup:
                        begin
                                if (way.hit)
                                begin
                                        resp_valid <= 1'b1;
                                        busy       <= 1'b0;
                                        state      <= idle;
                                end
                                else
                                begin
                                        miss_way <= way.victim_way;
                                        state    <= way.victim_dirty ? evict : refill;
                                end
                        end
                        evict:
                        begin
                                mem_write <= 1'b1;
                                state     <= evict_wait;
                        end
                        evict_wait:
                        begin
                                if (mem_done)
                                        state <= refill;   // write-back done first
                        end
                        refill:
                        begin
                                mem_read <= 1'b1;
                                state    <= refill_wait;
                        end
                        refill_wait:
                        begin
                                if (mem_done)
                                        state <= lookup;   // finish as a hit
                        end
                        default:
                                state <= idle;
                endcase
        end
end

// request payload and memory address/data
always_ff @(posedge clk)
begin
        if (accept)
        begin
                req_addr  <= addr_cpu;
                req_wdata <= wdata_cpu;
                req_byte  <= byte_sel;
        end
        if (state == evict)
        begin
                mem_addr  <= {way.victim_tag, way.index, {offset_bits{1'b0}}};
                mem_wdata <= line.victim_line;
        end
        else if (state == refill)
                mem_addr <= {req_addr[addr_w-1:offset_bits], {offset_bits{1'b0}}};
end

endmodule

// File: source/cache_top.sv
`timescale 1ns/1ns

module cache_top
        import cache_geom_pkg::*;
        #(parameter int sets = 2)
        (
        input  logic  clk,
        input  logic  reset,
        // cpu side
        input  logic  read_cpu,
        input  logic  write_cpu,
        input  logic  byte_sel,
        input  addr_t addr_cpu,
        input  word_t wdata_cpu,
        output word_t rdata_cpu,
        output logic  resp_valid,
        output logic  busy,
        // memory side
        output logic  mem_read,
        output logic  mem_write,
        output addr_t mem_addr,
        output line_t mem_wdata,
        input  line_t mem_rdata,
        input  logic  mem_done
        );

way_if  #(.sets(sets)) i_way  ();
line_if #(.sets(sets)) i_line ();

cache_control i_control (
        .clk        (clk),
        .reset      (reset),
        .read_cpu   (read_cpu),
        .write_cpu  (write_cpu),
        .byte_sel   (byte_sel),
        .addr_cpu   (addr_cpu),
        .wdata_cpu  (wdata_cpu),
        .mem_rdata  (mem_rdata),
        .mem_done   (mem_done),
        .resp_valid (resp_valid),
        .busy       (busy),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .way        (i_way.ctrl),
        .line       (i_line.ctrl)
);

tag_store #(.sets(sets)) i_tags (
        .clk   (clk),
        .reset (reset),
        .way   (i_way.store)
);

line_store #(.sets(sets)) i_lines (
        .clk   (clk),
        .reset (reset),
        .line  (i_line.store)
);

assign rdata_cpu = i_line.rdata;                    // valid in the resp_valid cycle

endmodule

// File: bench/cache_asserts.sv
`timescale 1ns/1ns

module cache_asserts
        (
        input logic clk,
        input logic reset,
        input logic busy,
        input logic resp_valid,
        input logic mem_read,
        input logic mem_write
        );

////////////////////////////////////////////////////////////////////////
// protocol rules on the top level strobes
////////////////////////////////////////////////////////////////////////

strobes_apart: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high in the same cycle");

// one response per request
resp_single: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid)
        else $error("resp_valid high for two cycles in a row");

mem_while_busy: assert property (@(posedge clk) disable iff (reset)
        (mem_read || mem_write) |-> busy)   // memory only talks during a miss
        else $error("memory strobe while busy is low");

endmodule

bind cache_top cache_asserts i_asserts (
        .clk        (clk),
        .reset      (reset),
        .busy       (busy),
        .resp_valid (resp_valid),
        .mem_read   (mem_read),
        .mem_write  (mem_write)
);

// File: bench/cache_tb.sv
`timescale 1ns/1ns

module cache_tb
        import cache_geom_pkg::*;
        import cache_ctrl_pkg::*;
        ();

localparam int sets      = 2;
localparam int idx_w     = $clog2(sets);
localparam int max_cases = 64;

logic  clk;
logic  reset;
logic  read_cpu;
logic  write_cpu;
logic  byte_sel;
addr_t addr_cpu;
word_t wdata_cpu;
word_t rdata_cpu;
logic  resp_valid;
logic  busy;
logic  mem_read;
logic  mem_write;
addr_t mem_addr;
line_t mem_wdata;
line_t mem_rdata;
logic  mem_done;

logic [31:0] case_mem [0:4*max_cases-1];   // op, byte_sel, address, data per case
word_t       arch [addr_t];                 // latest value of every written word
word_t       mem_store [addr_t];            // contents of the memory model
bit          sh_valid [0:1][0:sets-1];
bit          sh_dirty [0:1][0:sets-1];
addr_t       sh_tag [0:1][0:sets-1];
int          sh_lru [0:sets-1];             // victim way per set

bit    exp_wb;
addr_t exp_wb_addr;
line_t exp_wb_line;
bit    exp_rd;
addr_t exp_rd_addr;

int n_cases;
int checks;
int errors;
bit case_bad;
int cycle_count;
int timeout_limit;

cache_top #(.sets(sets)) i_cache_top (.*);

initial
begin
        clk = 1'b0;
        forever #20 clk = ~clk;
end

////////////////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // taps 32 22 2 1
        return {s[30:0], fb};
endfunction

function automatic int index_of(input addr_t a);
        return int'((a >> offset_bits) % sets);
endfunction

function automatic addr_t tag_of(input addr_t a);
        return a >> (offset_bits + idx_w);
endfunction

function automatic word_t arch_word(input addr_t a);
        if (arch.exists(a))
                return arch[a];
        return a ^ 32'h5a5a0000;                // never written
endfunction

function automatic line_t arch_line(input addr_t base);
        line_t l;
        for (int w = 0; w < words_per_line; w++)
                l[w*word_bits +: word_bits] = arch_word(base + addr_t'(4*w));
        return l;
endfunction

function automatic word_t memory_word(input addr_t a);
        if (mem_store.exists(a))
                return mem_store[a];
        return a ^ 32'h5a5a0000;
endfunction

function automatic line_t memory_line(input addr_t base);
        line_t l;
        for (int w = 0; w < words_per_line; w++)
                l[w*word_bits +: word_bits] = memory_word(base + addr_t'(4*w));
        return l;
endfunction

task automatic report_error(input string msg);
        errors++;
        case_bad = 1'b1;
        $display("[ERROR] %0t ns %s", $time, msg);
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act)
        begin
                errors++;
                case_bad = 1'b1;
                $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
endtask

task automatic check_line(input string name, input line_t exp, input line_t act);
        checks++;
        if (exp !== act)
        begin
                errors++;
                case_bad = 1'b1;
                $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        checks++;
        if (exp !== act)
        begin
                errors++;
                case_bad = 1'b1;
                $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
endtask

////////////////////////////////////////////////////////////////////////
// memory model
////////////////////////////////////////////////////////////////////////

initial
begin : memory_model
        addr_t       base;
        int          delay;
        bit          is_read;
        logic [31:0] lfsr;
        lfsr = 32'hbdd81600;
        mem_done  <= 1'b0;
        mem_rdata <= '0;
        forever
        begin
                @(negedge clk);
                if (mem_read || mem_write)
                begin
                        base    = mem_addr;
                        is_read = mem_read;         // strobe is gone by the answer
                        if (mem_write)
                                for (int w = 0; w < words_per_line; w++)
                                        mem_store[base + addr_t'(4*w)] =
                                                mem_wdata[w*word_bits +: word_bits];
                        delay = 1;                  // 1 to 8 cycles
                        for (int b = 0; b < 3; b++)
                        begin
                                lfsr = lfsr_next(lfsr);
                                if (lfsr[0])
                                        delay += (1 << b);
                        end
                        repeat (delay) @(posedge clk);
                        mem_done <= 1'b1;
                        if (is_read)
                                mem_rdata <= memory_line(base);
                        @(posedge clk);
                        mem_done <= 1'b0;
                end
        end
end

////////////////////////////////////////////////////////////////////////
// shadow model and case player
////////////////////////////////////////////////////////////////////////

// predicts memory traffic for one access and updates residency
task automatic predict_access(input cache_op_t op, input addr_t a, input word_t d);
        int    s;
        int    hw;
        addr_t t;
        s  = index_of(a);
        t  = tag_of(a);
        hw = -1;
        exp_wb = 1'b0;
        exp_rd = 1'b0;
        for (int w = 0; w < 2; w++)
                if (sh_valid[w][s] && sh_tag[w][s] == t)
                        hw = w;
        if (hw < 0)
        begin
                hw = sh_lru[s];
                if (sh_valid[hw][s] && sh_dirty[hw][s])
                begin
                        exp_wb      = 1'b1;
                        exp_wb_addr = (sh_tag[hw][s] << (offset_bits + idx_w))
                                      | (addr_t'(s) << offset_bits);
                        exp_wb_line = arch_line(exp_wb_addr);
                end
                exp_rd      = 1'b1;
                exp_rd_addr = (a >> offset_bits) << offset_bits;
                sh_valid[hw][s] = 1'b1;
                sh_dirty[hw][s] = 1'b0;
                sh_tag[hw][s]   = t;
        end
        sh_lru[s] = (hw == 0) ? 1 : 0;
        if (op == op_write)
        begin
                sh_dirty[hw][s] = 1'b1;
                arch[a & ~32'h3] = d;
        end
endtask

task automatic run_case(input int n);
        cache_op_t op;
        addr_t     a;
        word_t     d;
        logic      bsel;
        int        cyc;
        int        n_wr;
        int        n_rd;
        bit        done;
        op   = (case_mem[4*n] == 32'd1) ? op_write : op_read;
        bsel = case_mem[4*n+1][0];
        a    = case_mem[4*n+2];
        d    = case_mem[4*n+3];
        case_bad = 1'b0;
        predict_access(op, a, d);
        @(posedge clk);
        read_cpu  <= (op == op_read);
        write_cpu <= (op == op_write);
        byte_sel  <= bsel;
        addr_cpu  <= a;
        wdata_cpu <= d;
        @(posedge clk);                             // request edge
        read_cpu  <= 1'b0;
        write_cpu <= 1'b0;
        cyc  = 0;
        n_wr = 0;
        n_rd = 0;
        done = 1'b0;
        while (!done)
        begin
                @(negedge clk);
                cyc++;
                if (mem_write)
                begin
                        if (!exp_wb || n_wr > 0)
                                report_error("unexpected mem_write");
                        else
                        begin
                                if (n_rd > 0)
                                        report_error("write-back issued after refill read");
                                check_addr("mem_addr", exp_wb_addr, mem_addr);
                                check_line("mem_wdata", exp_wb_line, mem_wdata);
                        end
                        n_wr++;
                end
                if (mem_read)
                begin
                        if (!exp_rd || n_rd > 0)
                                report_error("unexpected mem_read");
                        else
                                check_addr("mem_addr", exp_rd_addr, mem_addr);
                        n_rd++;
                end
                if (resp_valid)
                begin
                        done = 1'b1;
                        if (busy)
                                report_error("busy still high in the response cycle");
                end
                else if (cyc >= 2 && !busy)
                        report_error("busy low while a request is in flight");
        end
        if (n_wr != (exp_wb ? 1 : 0))
                report_error("missing write-back of a dirty victim");
        if (n_rd != (exp_rd ? 1 : 0))
                report_error("missing refill read on a miss");
        if (!exp_rd && cyc != 3)
                report_error("hit response not in the cycle after the second edge");
        if (op == op_read)
                check_word("rdata_cpu", d, rdata_cpu);
        $display("case %0d %s addr %h byte %0d : %s", n, op.name(), a, bsel,
                 case_bad ? "fail" : "ok");
endtask

////////////////////////////////////////////////////////////////////////
// main sequence and timeout
////////////////////////////////////////////////////////////////////////

always @(posedge clk)
begin
        if (!reset)
                cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit)
        begin
                $display("timeout, no end of run within %0d cycles", timeout_limit);
                $display("SIMULATION FAILED");
                $finish;
        end
end

initial
begin
        reset     <= 1'b1;
        read_cpu  <= 1'b0;
        write_cpu <= 1'b0;
        byte_sel  <= 1'b0;
        addr_cpu  <= '0;
        wdata_cpu <= '0;
        checks = 0;
        errors = 0;
        cycle_count   = 0;
        timeout_limit = 0;
        for (int i = 0; i < 4*max_cases; i++)
                case_mem[i] = 32'hf;                // end marker everywhere
        $readmemh("bench/cache_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < max_cases && case_mem[4*n_cases] != 32'hf)
                n_cases++;
        if (n_cases == 0)
                report_error("case file holds no cases");
        timeout_limit = n_cases * 40;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (busy || resp_valid || mem_read || mem_write)
                report_error("busy, resp_valid or memory strobe high after reset");

        for (int n = 0; n < n_cases; n++)
                run_case(n);

        $display("summary %0d cases, %0d checks, %0d errors", n_cases, checks, errors);
        if (errors == 0)
                $display("SIMULATION PASSED");
        else
                $display("SIMULATION FAILED");
        $finish;
end

endmodule

// File: bench/cache_cases.txt
// op (0 read, 1 write, f end)  byte_sel  address  data
// data is the write data on writes and the expected rdata_cpu on reads
0 0 00001004 5a5a1004
0 0 00001004 5a5a1004
0 1 00001006 0000005a
0 1 00001005 00000010
1 0 00001008 deadbeef
0 0 00001008 deadbeef
1 0 00002004 11223344
0 0 0000200c 5a5a200c
0 0 00002004 11223344
0 0 00003000 5a5a3000
0 0 00001008 deadbeef
0 0 00001010 5a5a1010
0 0 00002014 5a5a2014
0 0 0000301c 5a5a301c
0 0 00001018 5a5a1018
0 0 00002004 11223344
1 0 0000300c cafef00d
0 1 0000300f 000000ca
0 0 00001000 5a5a1000
0 0 00002000 5a5a2000
0 0 0000300c cafef00d
f 0 00000000 00000000

// File: list.f
source/cache_geom_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_ifs.sv
source/tag_store.sv
source/line_store.sv
source/cache_control.sv
source/cache_top.sv
bench/cache_asserts.sv
bench/cache_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the cache testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module cache_tb \
		-f list.f --Mdir obj_dir -o cache_sim
	./obj_dir/cache_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
